//--- source/decode_pkg.sv
package decode_pkg;

  ////////////////////////////////////////
  // instruction word formats
  ////////////////////////////////////////

  localparam logic [1:0] SOP2_TAG = 2'b10;
  localparam logic [1:0] SOPP_TAG = 2'b11;

  // scalar two operand
  typedef struct packed {
    logic [1:0] tag;
    logic [6:0] opcode;
    logic [6:0] sdst;
    logic [7:0] ssrc1;
    logic [7:0] ssrc0;
  } sop2_t;

  // scalar control
  typedef struct packed {
    logic [1:0]  tag;
    logic [6:0]  opcode;
    logic [6:0]  unused;
    logic [15:0] simm16;
  } sopp_t;

  // vector two operand, bit 31 is zero
  typedef struct packed {
    logic       tag;
    logic [5:0] opcode;
    logic [7:0] vdst;
    logic [7:0] vsrc1;
    logic [8:0] src0;
  } vop2_t;

  typedef union packed {
    sop2_t sop2;
    sopp_t sopp;
    vop2_t vop2;
  } instr_word_u;

  ////////////////////////////////////////
  // opcodes, format code in bits 31:24
  ////////////////////////////////////////

  localparam logic [7:0] FMT_VOP2 = 8'h00;
  localparam logic [7:0] FMT_SOP2 = 8'h02;
  localparam logic [7:0] FMT_SOPP = 8'h03;

  localparam logic [31:0] OP_S_ENDPGM       = {FMT_SOPP, 24'd1};
  localparam logic [31:0] OP_S_BRANCH       = {FMT_SOPP, 24'd2};
  localparam logic [31:0] OP_S_CBRANCH_SCC1 = {FMT_SOPP, 24'd5};
  localparam logic [31:0] OP_S_BARRIER      = {FMT_SOPP, 24'd10};
  localparam logic [31:0] OP_S_WAITCNT      = {FMT_SOPP, 24'd12};

  localparam logic [31:0] OP_S_ADD_U32      = {FMT_SOP2, 24'd0};
  localparam logic [31:0] OP_S_MOV_B32      = {FMT_SOP2, 24'd3};
  localparam logic [31:0] OP_S_MOV_B64      = {FMT_SOP2, 24'd4};
  localparam logic [31:0] OP_S_CSELECT_B32  = {FMT_SOP2, 24'd10};

  localparam logic [31:0] OP_V_MOV_B32      = {FMT_VOP2, 24'd1};
  localparam logic [31:0] OP_V_ADD_F32      = {FMT_VOP2, 24'd3};
  localparam logic [31:0] OP_V_MAC_F32      = {FMT_VOP2, 24'd31};
  localparam logic [31:0] OP_V_ADD_I32      = {FMT_VOP2, 24'd37};
  localparam logic [31:0] OP_V_ADDC_U32     = {FMT_VOP2, 24'd40};

  ////////////////////////////////////////
  // operand field codes on the 10-bit scale
  ////////////////////////////////////////

  localparam logic [9:0] FIELD_SGPR_LAST  = 10'd103;
  localparam logic [9:0] FIELD_VCC        = 10'd106;
  localparam logic [9:0] FIELD_M0         = 10'd124;
  localparam logic [9:0] FIELD_EXEC       = 10'd126;
  localparam logic [9:0] FIELD_FP_FIRST   = 10'd240;
  localparam logic [9:0] FIELD_FP_LAST    = 10'd247;
  localparam logic [9:0] FIELD_SCC        = 10'd253;
  localparam logic [9:0] FIELD_LITERAL    = 10'd255;
  localparam logic [9:0] FIELD_VGPR_FIRST = 10'd256;

  // +0.5 -0.5 +1.0 -1.0 +2.0 -2.0 +4.0 -4.0
  localparam logic [0:7][31:0] FP_CONST_TABLE = {
    32'h3F00_0000, 32'hBF00_0000, 32'h3F80_0000, 32'hBF80_0000,
    32'h4000_0000, 32'hC000_0000, 32'h4080_0000, 32'hC080_0000
  };

endpackage

//--- source/issue_pkg.sv
package issue_pkg;

  typedef struct packed {
    logic [5:0] wfid;
    logic [8:0] sgpr_base;
    logic [9:0] vgpr_base;
  } wave_ctx_t;

  // width counts registers, 0 means unused
  typedef struct packed {
    logic [1:0] width;
    logic       valid;
    logic       vector;
    logic [9:0] addr;
  } op_desc_t;

  typedef struct packed {
    logic halt;
    logic barrier;
    logic branch;
    logic waitcnt;
    logic vcc_rd;
    logic vcc_wr;
    logic scc_rd;
    logic scc_wr;
    logic exec_rd;
    logic exec_wr;
    logic m0_rd;
    logic m0_wr;
  } issue_flags_t;

  typedef struct packed {
    logic vcc;
    logic scc;
    logic exec;
    logic m0;
  } special_use_t;

  localparam logic [1:0] FU_SALU = 2'd1;
  localparam logic [1:0] FU_VALU = 2'd2;
  localparam logic [1:0] FU_CTRL = 2'd3;

  typedef struct packed {
    logic [1:0]   fu;
    logic [31:0]  opcode;
    logic [15:0]  imm0;
    logic [31:0]  imm1;
    op_desc_t     src1;
    op_desc_t     src2;
    op_desc_t     src3;
    op_desc_t     dst1;
    issue_flags_t flags;
    logic [31:0]  pc;
    logic [5:0]   wfid;
  } issue_bundle_t;

endpackage

//--- source/wave_stage_flops.sv
`timescale 1ns/1ps

module wave_stage_flops (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    in_valid,
  input  decode_pkg::instr_word_u in_instr,
  input  logic [31:0]             in_pc,
  input  issue_pkg::wave_ctx_t    in_ctx,
  output logic                    out_valid,
  output decode_pkg::instr_word_u out_instr,
  output logic [31:0]             out_pc,
  output issue_pkg::wave_ctx_t    out_ctx
);

  always_ff @(posedge clk)
  begin
    if (!rst_n)
      out_valid <= 1'b0;
    else
      out_valid <= in_valid;
  end

  // payload only moves with a valid word
  always_ff @(posedge clk)
  begin
    if (in_valid)
    begin
      out_instr <= in_instr;
      out_pc    <= in_pc;
      out_ctx   <= in_ctx;
    end
  end

endmodule

//--- source/decode_core.sv
`timescale 1ns/1ps

module decode_core (
  input  decode_pkg::instr_word_u instr,
  output logic                    is_vector,
  output logic                    is_control,
  output logic [31:0]             opcode,
  output logic [15:0]             imm0,
  output logic [9:0]              src0_field,
  output logic [9:0]              src1_field,
  output logic [9:0]              dst_field
);

  import decode_pkg::*;

  // bit 31 clear marks a vector word
  assign is_vector  = (instr.vop2.tag == 1'b0);
  assign is_control = (instr.sopp.tag == SOPP_TAG);

  always_comb
  begin
    opcode     = '0;
    imm0       = '0;
    src0_field = '0;
    src1_field = '0;
    dst_field  = '0;
    if (is_vector)
    begin
      opcode     = {FMT_VOP2, 18'd0, instr.vop2.opcode};
      // src0 already spans sgpr and vgpr codes
      src0_field = {1'b0, instr.vop2.src0};
      src1_field = FIELD_VGPR_FIRST + {2'b00, instr.vop2.vsrc1};
      dst_field  = FIELD_VGPR_FIRST + {2'b00, instr.vop2.vdst};
    end
    else if (is_control)
    begin
      opcode = {FMT_SOPP, 17'd0, instr.sopp.opcode};
      imm0   = instr.sopp.simm16;
    end
    else
    begin
      // remaining tag is SOP2_TAG
      opcode     = {FMT_SOP2, 17'd0, instr.sop2.opcode};
      src0_field = {2'b00, instr.sop2.ssrc0};
      src1_field = {2'b00, instr.sop2.ssrc1};
      dst_field  = {3'b000, instr.sop2.sdst};
    end
  end

endmodule

//--- source/flag_generator.sv
`timescale 1ns/1ps

module flag_generator (
  input  logic [31:0]             opcode,
  input  logic                    is_vector,
  input  logic                    is_control,
  output logic [1:0]              fu,
  output issue_pkg::issue_flags_t ctrl,
  output issue_pkg::special_use_t imp_rd,
  output issue_pkg::special_use_t imp_wr,
  output logic [1:0]              s1_width,
  output logic [1:0]              s2_width,
  output logic [1:0]              s3_width,
  output logic [1:0]              d1_width,
  output logic                    copy_d1_to_s3
);

  import decode_pkg::*;
  import issue_pkg::*;

  assign fu = is_control ? FU_CTRL : (is_vector ? FU_VALU : FU_SALU);

  always_comb
  begin
    ctrl          = '0;
    imp_rd        = '0;
    imp_wr        = '0;
    s1_width      = 2'd1;
    s2_width      = 2'd1;
    s3_width      = 2'd0;
    d1_width      = 2'd1;
    copy_d1_to_s3 = 1'b0;

    // every vector op is masked by exec
    imp_rd.exec = is_vector;

    case (opcode)
      OP_S_ENDPGM:  ctrl.halt    = 1'b1;
      OP_S_BARRIER: ctrl.barrier = 1'b1;
      OP_S_BRANCH:  ctrl.branch  = 1'b1;
      OP_S_WAITCNT: ctrl.waitcnt = 1'b1;
      OP_S_CBRANCH_SCC1:
      begin
        ctrl.branch = 1'b1;
        imp_rd.scc  = 1'b1;
      end
      OP_S_MOV_B32, OP_V_MOV_B32: s2_width = 2'd0;
      OP_S_MOV_B64:
      begin
        s1_width = 2'd2;
        s2_width = 2'd0;
        d1_width = 2'd2;
      end
      OP_S_ADD_U32:     imp_wr.scc = 1'b1;
      OP_S_CSELECT_B32: imp_rd.scc = 1'b1;
      OP_V_ADD_I32:     imp_wr.vcc = 1'b1;
      // carry in and carry out
      OP_V_ADDC_U32:
      begin
        imp_rd.vcc = 1'b1;
        imp_wr.vcc = 1'b1;
      end
      // accumulator is the destination
      OP_V_MAC_F32:
      begin
        s3_width      = 2'd1;
        copy_d1_to_s3 = 1'b1;
      end
      default: ;
    endcase

    if (is_control)
    begin
      s1_width = 2'd0;
      s2_width = 2'd0;
      d1_width = 2'd0;
    end
  end

endmodule

//--- source/reg_field_encoder.sv
`timescale 1ns/1ps

module reg_field_encoder (
  input  logic [9:0]              field,
  input  issue_pkg::wave_ctx_t    ctx,
  output issue_pkg::op_desc_t     desc,
  output issue_pkg::special_use_t explicit,
  output logic                    literal_required,
  output logic                    fp_valid,
  output logic [31:0]             fp_value
);

  import decode_pkg::*;

  logic [2:0] fp_idx;

  assign fp_idx = 3'(field - FIELD_FP_FIRST);

  always_comb
  begin
    desc             = '0;
    explicit         = '0;
    literal_required = 1'b0;
    fp_valid         = 1'b0;
    fp_value         = '0;
    if (field >= FIELD_VGPR_FIRST)
    begin
      desc.valid  = 1'b1;
      desc.vector = 1'b1;
      desc.addr   = ctx.vgpr_base + (field - FIELD_VGPR_FIRST);
    end
    else if (field <= FIELD_SGPR_LAST)
    begin
      desc.valid = 1'b1;
      desc.addr  = {1'b0, ctx.sgpr_base} + field;
    end
    else if ((field >= FIELD_FP_FIRST) && (field <= FIELD_FP_LAST))
    begin
      fp_valid = 1'b1;
      fp_value = FP_CONST_TABLE[fp_idx];
    end
    else
    begin
      case (field)
        FIELD_VCC:     explicit.vcc     = 1'b1;
        FIELD_SCC:     explicit.scc     = 1'b1;
        FIELD_EXEC:    explicit.exec    = 1'b1;
        FIELD_M0:      explicit.m0      = 1'b1;
        FIELD_LITERAL: literal_required = 1'b1;
        default: ;
      endcase
    end
  end

endmodule

//--- source/instr_collate.sv
`timescale 1ns/1ps

module instr_collate (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     in_valid,
  input  logic [31:0]              in_instr,
  input  issue_pkg::issue_bundle_t in_bundle,
  input  logic                     needs_literal,
  output logic                     issue_valid,
  output issue_pkg::issue_bundle_t issue,
  output logic [63:0]              trace_instr,
  output logic                     wave_ins_half_rqd,
  output logic [5:0]               wave_ins_half_wfid
);

  logic pending;
  logic take_literal;
  logic hold_word;

  // a word arriving while pending is the literal
  assign take_literal = in_valid & pending;
  assign hold_word    = in_valid & ~pending & needs_literal;

  assign wave_ins_half_rqd  = hold_word;
  assign wave_ins_half_wfid = in_bundle.wfid;

  ////////////////////////////////////////
  // control
  ////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      pending     <= 1'b0;
      issue_valid <= 1'b0;
    end
    else
    begin
      pending     <= pending ? ~in_valid : hold_word;
      issue_valid <= in_valid & (pending | ~needs_literal);
    end
  end

  ////////////////////////////////////////
  // issue register
  ////////////////////////////////////////

  // held bundle sits in the issue register until its literal shows up
  always_ff @(posedge clk)
  begin
    if (take_literal)
    begin
      issue.imm1         <= in_instr;
      trace_instr[63:32] <= in_instr;
    end
    else if (in_valid)
    begin
      issue       <= in_bundle;
      trace_instr <= {32'd0, in_instr};
    end
  end

endmodule

//--- source/decode.sv
`timescale 1ns/1ps

module decode (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     wave_instr_valid,
  input  logic [31:0]              wave_instr,
  input  logic [31:0]              wave_instr_pc,
  input  issue_pkg::wave_ctx_t     wave_ctx,
  output logic                     issue_valid,
  output issue_pkg::issue_bundle_t issue,
  output logic [63:0]              trace_instr,
  output logic                     wave_ins_half_rqd,
  output logic [5:0]               wave_ins_half_wfid
);

  import decode_pkg::*;
  import issue_pkg::*;

  logic          flop_valid;
  instr_word_u   flop_instr;
  logic [31:0]   flop_pc;
  wave_ctx_t     flop_ctx;

  logic          is_vector;
  logic          is_control;
  logic [31:0]   opcode;
  logic [15:0]   imm0;
  logic [9:0]    src0_field;
  logic [9:0]    src1_field;
  logic [9:0]    dst_field;

  logic [1:0]    fu;
  issue_flags_t  ctrl_flags;
  special_use_t  imp_rd;
  special_use_t  imp_wr;
  logic          copy_d1_to_s3;

  // operand slots 0 to 2 are s1 to s3, slot 3 is d1
  logic [9:0]    enc_field [4];
  logic [1:0]    enc_width [4];
  op_desc_t      enc_desc [4];
  op_desc_t      op_desc [4];
  special_use_t  enc_spec [4];
  special_use_t  used_spec [4];
  logic [31:0]   enc_fp [4];
  logic [3:0]    enc_used;
  logic [3:0]    enc_lit;
  logic [3:0]    enc_fp_valid;

  special_use_t  rd_use;
  special_use_t  wr_use;
  issue_flags_t  flags;
  logic [31:0]   imm1;
  logic          needs_literal;
  issue_bundle_t pre_issue;

  wave_stage_flops u_flops (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (wave_instr_valid),
    .in_instr  (wave_instr),
    .in_pc     (wave_instr_pc),
    .in_ctx    (wave_ctx),
    .out_valid (flop_valid),
    .out_instr (flop_instr),
    .out_pc    (flop_pc),
    .out_ctx   (flop_ctx)
  );

  decode_core u_core (
    .instr      (flop_instr),
    .is_vector  (is_vector),
    .is_control (is_control),
    .opcode     (opcode),
    .imm0       (imm0),
    .src0_field (src0_field),
    .src1_field (src1_field),
    .dst_field  (dst_field)
  );

  flag_generator u_flags (
    .opcode        (opcode),
    .is_vector     (is_vector),
    .is_control    (is_control),
    .fu            (fu),
    .ctrl          (ctrl_flags),
    .imp_rd        (imp_rd),
    .imp_wr        (imp_wr),
    .s1_width      (enc_width[0]),
    .s2_width      (enc_width[1]),
    .s3_width      (enc_width[2]),
    .d1_width      (enc_width[3]),
    .copy_d1_to_s3 (copy_d1_to_s3)
  );

  ////////////////////////////////////////
  // operand encoding
  ////////////////////////////////////////

  assign enc_field[0] = src0_field;
  assign enc_field[1] = src1_field;
  assign enc_field[2] = copy_d1_to_s3 ? dst_field : 10'd0;
  assign enc_field[3] = dst_field;

  for (genvar i = 0; i < 4; i++)
  begin : g_enc
    reg_field_encoder u_enc (
      .field            (enc_field[i]),
      .ctx              (flop_ctx),
      .desc             (enc_desc[i]),
      .explicit         (enc_spec[i]),
      .literal_required (enc_lit[i]),
      .fp_valid         (enc_fp_valid[i]),
      .fp_value         (enc_fp[i])
    );

    // an operand of width zero is ignored entirely
    assign enc_used[i]  = (enc_width[i] != 2'd0);
    assign used_spec[i] = enc_used[i] ? enc_spec[i] : '0;
    assign op_desc[i]   = '{width:  enc_width[i],
                            valid:  enc_desc[i].valid & enc_used[i],
                            vector: enc_desc[i].vector,
                            addr:   enc_desc[i].addr};
  end

  ////////////////////////////////////////
  // flag merge and immediates
  ////////////////////////////////////////

  assign rd_use = imp_rd | used_spec[0] | used_spec[1] | used_spec[2];
  assign wr_use = imp_wr | used_spec[3];

  always_comb
  begin
    flags         = ctrl_flags;
    flags.vcc_rd  = rd_use.vcc;
    flags.vcc_wr  = wr_use.vcc;
    flags.scc_rd  = rd_use.scc;
    flags.scc_wr  = wr_use.scc;
    flags.exec_rd = rd_use.exec;
    flags.exec_wr = wr_use.exec;
    flags.m0_rd   = rd_use.m0;
    flags.m0_wr   = wr_use.m0;
  end

  // first inline float constant wins, s1 before s2 before s3
  always_comb
  begin
    if (enc_used[0] && enc_fp_valid[0])
      imm1 = enc_fp[0];
    else if (enc_used[1] && enc_fp_valid[1])
      imm1 = enc_fp[1];
    else if (enc_used[2] && enc_fp_valid[2])
      imm1 = enc_fp[2];
    else
      imm1 = '0;
  end

  assign needs_literal = |(enc_lit[2:0] & enc_used[2:0]);

  always_comb
  begin
    pre_issue.fu     = fu;
    pre_issue.opcode = opcode;
    pre_issue.imm0   = imm0;
    pre_issue.imm1   = imm1;
    pre_issue.src1   = op_desc[0];
    pre_issue.src2   = op_desc[1];
    pre_issue.src3   = op_desc[2];
    pre_issue.dst1   = op_desc[3];
    pre_issue.flags  = flags;
    pre_issue.pc     = flop_pc;
    pre_issue.wfid   = flop_ctx.wfid;
  end

  instr_collate u_collate (
    .clk                (clk),
    .rst_n              (rst_n),
    .in_valid           (flop_valid),
    .in_instr           (flop_instr),
    .in_bundle          (pre_issue),
    .needs_literal      (needs_literal),
    .issue_valid        (issue_valid),
    .issue              (issue),
    .trace_instr        (trace_instr),
    .wave_ins_half_rqd  (wave_ins_half_rqd),
    .wave_ins_half_wfid (wave_ins_half_wfid)
  );

endmodule

//--- tb/decode_ref.svh
`ifndef DECODE_REF_SVH
`define DECODE_REF_SVH

////////////////////////////////////////
// expected issue bundle
////////////////////////////////////////

// +0.5 -0.5 +1.0 -1.0 +2.0 -2.0 +4.0 -4.0
function automatic logic [31:0] fp_inline_value(input logic [2:0] idx);
  case (idx)
    3'd0: return 32'h3F00_0000;
    3'd1: return 32'hBF00_0000;
    3'd2: return 32'h3F80_0000;
    3'd3: return 32'hBF80_0000;
    3'd4: return 32'h4000_0000;
    3'd5: return 32'hC000_0000;
    3'd6: return 32'h4080_0000;
    default: return 32'hC080_0000;
  endcase
endfunction

// one operand slot, side effects only count when width is nonzero
function automatic op_desc_t operand_ref(input logic [9:0] field, input wave_ctx_t ctx,
                                         input logic [1:0] width,
                                         output special_use_t spec, output logic lit,
                                         output logic fp_ok, output logic [31:0] fp);
  op_desc_t d;
  logic     used;
  used  = (width != 2'd0);
  d     = '0;
  spec  = '0;
  lit   = 1'b0;
  fp_ok = 1'b0;
  fp    = '0;
  d.width = width;
  if (field >= 10'd256)
  begin
    d.valid  = used;
    d.vector = 1'b1;
    d.addr   = ctx.vgpr_base + (field - 10'd256);
  end
  else if (field <= 10'd103)
  begin
    d.valid = used;
    d.addr  = ctx.sgpr_base + field;
  end
  else if ((field >= 10'd240) && (field <= 10'd247))
  begin
    fp_ok = used;
    fp    = fp_inline_value(field[2:0]);
  end
  else if (used)
  begin
    case (field)
      FIELD_VCC:     spec.vcc  = 1'b1;
      FIELD_M0:      spec.m0   = 1'b1;
      FIELD_EXEC:    spec.exec = 1'b1;
      FIELD_SCC:     spec.scc  = 1'b1;
      FIELD_LITERAL: lit       = 1'b1;
      default: ;
    endcase
  end
  return d;
endfunction

function automatic issue_bundle_t ref_bundle(input logic [31:0] w, input wave_ctx_t ctx,
                                             input logic [31:0] pc, output logic need_lit);
  issue_bundle_t b;
  logic [9:0]    f0;
  logic [9:0]    f1;
  logic [9:0]    f3;
  logic [9:0]    fd;
  logic [1:0]    w1;
  logic [1:0]    w2;
  logic [1:0]    w3;
  logic [1:0]    wd;
  logic          copy;
  special_use_t  rd;
  special_use_t  wr;
  special_use_t  sp1;
  special_use_t  sp2;
  special_use_t  sp3;
  special_use_t  spd;
  logic          l1;
  logic          l2;
  logic          l3;
  logic          ld;
  logic          v1;
  logic          v2;
  logic          v3;
  logic          vd;
  logic [31:0]   c1;
  logic [31:0]   c2;
  logic [31:0]   c3;
  logic [31:0]   cd;
  b    = '0;
  f0   = '0;
  f1   = '0;
  fd   = '0;
  rd   = '0;
  wr   = '0;
  w1   = 2'd1;
  w2   = 2'd1;
  w3   = 2'd0;
  wd   = 2'd1;
  copy = 1'b0;
  if (!w[31])
  begin
    b.fu     = FU_VALU;
    b.opcode = {8'h00, 18'd0, w[30:25]};
    f0       = {1'b0, w[8:0]};
    f1       = 10'd256 + w[16:9];
    fd       = 10'd256 + w[24:17];
    rd.exec  = 1'b1;
  end
  else if (w[30])
  begin
    b.fu     = FU_CTRL;
    b.opcode = {8'h03, 17'd0, w[29:23]};
    b.imm0   = w[15:0];
  end
  else
  begin
    b.fu     = FU_SALU;
    b.opcode = {8'h02, 17'd0, w[29:23]};
    f0       = {2'b00, w[7:0]};
    f1       = {2'b00, w[15:8]};
    fd       = {3'b000, w[22:16]};
  end
  case (b.opcode)
    OP_S_ENDPGM:  b.flags.halt    = 1'b1;
    OP_S_BARRIER: b.flags.barrier = 1'b1;
    OP_S_BRANCH:  b.flags.branch  = 1'b1;
    OP_S_WAITCNT: b.flags.waitcnt = 1'b1;
    OP_S_CBRANCH_SCC1:
    begin
      b.flags.branch = 1'b1;
      rd.scc         = 1'b1;
    end
    OP_S_MOV_B32, OP_V_MOV_B32: w2 = 2'd0;
    OP_S_MOV_B64:
    begin
      w1 = 2'd2;
      w2 = 2'd0;
      wd = 2'd2;
    end
    OP_S_ADD_U32:     wr.scc = 1'b1;
    OP_S_CSELECT_B32: rd.scc = 1'b1;
    OP_V_ADD_I32:     wr.vcc = 1'b1;
    OP_V_ADDC_U32:
    begin
      rd.vcc = 1'b1;
      wr.vcc = 1'b1;
    end
    OP_V_MAC_F32:
    begin
      w3   = 2'd1;
      copy = 1'b1;
    end
    default: ;
  endcase
  if (b.fu == FU_CTRL)
  begin
    w1 = 2'd0;
    w2 = 2'd0;
    wd = 2'd0;
  end
  f3     = copy ? fd : 10'd0;
  b.src1 = operand_ref(f0, ctx, w1, sp1, l1, v1, c1);
  b.src2 = operand_ref(f1, ctx, w2, sp2, l2, v2, c2);
  b.src3 = operand_ref(f3, ctx, w3, sp3, l3, v3, c3);
  b.dst1 = operand_ref(fd, ctx, wd, spd, ld, vd, cd);
  rd = rd | sp1 | sp2 | sp3;
  wr = wr | spd;
  b.flags.vcc_rd  = rd.vcc;
  b.flags.vcc_wr  = wr.vcc;
  b.flags.scc_rd  = rd.scc;
  b.flags.scc_wr  = wr.scc;
  b.flags.exec_rd = rd.exec;
  b.flags.exec_wr = wr.exec;
  b.flags.m0_rd   = rd.m0;
  b.flags.m0_wr   = wr.m0;
  if (v1)
    b.imm1 = c1;
  else if (v2)
    b.imm1 = c2;
  else if (v3)
    b.imm1 = c3;
  need_lit = l1 | l2 | l3;
  b.pc     = pc;
  b.wfid   = ctx.wfid;
  return b;
endfunction

`endif

//--- tb/tb_decode.sv
`timescale 1ns/1ps

module tb_decode;

  import decode_pkg::*;
  import issue_pkg::*;

  `include "decode_ref.svh"

  localparam int NUM_INSTR   = 400;
  localparam int CYCLE_LIMIT = NUM_INSTR * 8 + 20;

  logic          clk;
  logic          rst_n;
  logic          wave_instr_valid;
  logic [31:0]   wave_instr;
  logic [31:0]   wave_instr_pc;
  wave_ctx_t     wave_ctx;
  logic          issue_valid;
  issue_bundle_t issue;
  logic [63:0]   trace_instr;
  logic          wave_ins_half_rqd;
  logic [5:0]    wave_ins_half_wfid;

  int            cycle_cnt = 0;
  logic [31:0]   rng_state = 32'd10535;

  // expected results in issue order
  issue_bundle_t exp_bundle_q[$];
  logic [63:0]   exp_trace_q[$];
  int            exp_cycle_q[$];

  decode decode_i (
    .clk                (clk),
    .rst_n              (rst_n),
    .wave_instr_valid   (wave_instr_valid),
    .wave_instr         (wave_instr),
    .wave_instr_pc      (wave_instr_pc),
    .wave_ctx           (wave_ctx),
    .issue_valid        (issue_valid),
    .issue              (issue),
    .trace_instr        (trace_instr),
    .wave_ins_half_rqd  (wave_ins_half_rqd),
    .wave_ins_half_wfid (wave_ins_half_wfid)
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk)
    cycle_cnt <= cycle_cnt + 1;

  initial
  begin
    repeat (CYCLE_LIMIT) @(posedge clk);
    $display("timeout after %0d cycles, DUT stopped issuing", CYCLE_LIMIT);
    $display("Testbench failed");
    $fatal(1, "run aborted");
  end

  ////////////////////////////////////////
  // random stimulus
  ////////////////////////////////////////

  function automatic logic [31:0] next_rand();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  function automatic int rand_below(input int n);
    return int'((next_rand() >> 16) % n);
  endfunction

  function automatic logic [31:0] pick_opcode();
    case (rand_below(14))
      0:  return OP_S_ENDPGM;
      1:  return OP_S_BARRIER;
      2:  return OP_S_BRANCH;
      3:  return OP_S_CBRANCH_SCC1;
      4:  return OP_S_WAITCNT;
      5:  return OP_S_MOV_B32;
      6:  return OP_S_MOV_B64;
      7:  return OP_S_ADD_U32;
      8:  return OP_S_CSELECT_B32;
      9:  return OP_V_MOV_B32;
      10: return OP_V_ADD_F32;
      11: return OP_V_ADD_I32;
      12: return OP_V_ADDC_U32;
      default: return OP_V_MAC_F32;
    endcase
  endfunction

  // source code from every class, vgpr only where the format has room
  function automatic logic [9:0] pick_src_field(input logic vgpr_ok);
    logic [9:0] f;
    case (rand_below(8))
      0, 1, 2: f = 10'(rand_below(104));
      3:
      begin
        case (rand_below(4))
          0:       f = FIELD_VCC;
          1:       f = FIELD_M0;
          2:       f = FIELD_EXEC;
          default: f = FIELD_SCC;
        endcase
      end
      4:       f = FIELD_FP_FIRST + 10'(rand_below(8));
      5:       f = FIELD_LITERAL;
      6:       f = 10'd200;
      default: f = vgpr_ok ? FIELD_VGPR_FIRST + 10'(rand_below(256)) : 10'(rand_below(104));
    endcase
    return f;
  endfunction

  function automatic logic [6:0] pick_dst_field();
    case (rand_below(6))
      0:       return 7'(FIELD_VCC);
      1:       return 7'(FIELD_M0);
      2:       return 7'(FIELD_EXEC);
      default: return 7'(rand_below(104));
    endcase
  endfunction

  function automatic logic [31:0] build_word(input logic [31:0] op);
    logic [9:0] s0;
    logic [9:0] s1;
    s0 = pick_src_field(op[31:24] == FMT_VOP2);
    s1 = pick_src_field(1'b0);
    case (op[31:24])
      FMT_VOP2: return {1'b0, op[5:0], 8'(next_rand() >> 8), 8'(next_rand() >> 8), s0[8:0]};
      FMT_SOP2: return {2'b10, op[6:0], pick_dst_field(), s1[7:0], s0[7:0]};
      default:  return {2'b11, op[6:0], 7'(next_rand() >> 9), 16'(next_rand() >> 12)};
    endcase
  endfunction

  ////////////////////////////////////////
  // checking
  ////////////////////////////////////////

  task automatic check_value(input string what, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp)
    begin
      $display("FAIL at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      $display("Testbench failed");
      $fatal(1, "stopping on first error");
    end
  endtask

  // one word into the stage flops, returns at edge plus 1 ns
  task automatic drive_word(input logic [31:0] word, input logic [31:0] pc,
                            input wave_ctx_t ctx);
    wave_instr_valid = 1'b1;
    wave_instr       = word;
    wave_instr_pc    = pc;
    wave_ctx         = ctx;
    @(posedge clk);
    #1;
    wave_instr_valid = 1'b0;
  endtask

  // scoreboard
  initial
  begin
    issue_bundle_t e;
    logic [63:0]   et;
    int            ec;
    forever
    begin
      @(negedge clk);
      if (issue_valid === 1'b1)
      begin
        if (exp_bundle_q.size() == 0)
        begin
          $display("issue_valid went high at %0t ns with no instruction outstanding", $time);
          $display("Testbench failed");
          $fatal(1, "unexpected issue");
        end
        else
        begin
          e  = exp_bundle_q.pop_front();
          et = exp_trace_q.pop_front();
          ec = exp_cycle_q.pop_front();
          check_value("issue cycle", cycle_cnt, ec);
          check_value("fu", issue.fu, e.fu);
          check_value("opcode", issue.opcode, e.opcode);
          check_value("imm0", issue.imm0, e.imm0);
          check_value("imm1", issue.imm1, e.imm1);
          check_value("src1", issue.src1, e.src1);
          check_value("src2", issue.src2, e.src2);
          check_value("src3", issue.src3, e.src3);
          check_value("dst1", issue.dst1, e.dst1);
          check_value("flags", issue.flags, e.flags);
          check_value("pc", issue.pc, e.pc);
          check_value("wfid", issue.wfid, e.wfid);
          check_value("trace_instr", trace_instr, et);
        end
      end
    end
  end

  ////////////////////////////////////////
  // reset, instruction stream, wavepool
  ////////////////////////////////////////

  initial
  begin
    issue_bundle_t exp;
    logic [31:0]   op;
    logic [31:0]   word;
    logic [31:0]   pc;
    logic [31:0]   literal;
    wave_ctx_t     ctx;
    logic          need;
    rst_n            = 1'b0;
    wave_instr_valid = 1'b0;
    wave_instr       = '0;
    wave_instr_pc    = '0;
    wave_ctx         = '0;
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;

    // idle after reset
    repeat (3)
    begin
      @(posedge clk);
      #1;
      check_value("issue_valid after reset", issue_valid, 1'b0);
      check_value("half_rqd after reset", wave_ins_half_rqd, 1'b0);
    end

    for (int n = 0; n < NUM_INSTR; n++)
    begin
      op      = pick_opcode();
      word    = build_word(op);
      pc      = next_rand();
      ctx     = 25'(next_rand() >> 7);
      literal = next_rand();
      exp     = ref_bundle(word, ctx, pc, need);
      if (need)
        exp.imm1 = literal;
      repeat (rand_below(3))
      begin
        @(posedge clk);
        #1;
      end
      drive_word(word, pc, ctx);
      check_value("half_rqd", wave_ins_half_rqd, need);
      if (need)
      begin
        check_value("half_wfid", wave_ins_half_wfid, ctx.wfid);
        repeat (rand_below(4))
        begin
          @(posedge clk);
          #1;
          check_value("half_rqd while pending", wave_ins_half_rqd, 1'b0);
        end
        // pc and context of the literal word must be ignored
        drive_word(literal, next_rand(), 25'(next_rand()));
        check_value("half_rqd on literal", wave_ins_half_rqd, 1'b0);
      end
      exp_bundle_q.push_back(exp);
      exp_trace_q.push_back(need ? {literal, word} : {32'd0, word});
      // stage flops took the word at the last edge, issue register loads on the next
      exp_cycle_q.push_back(cycle_cnt + 1);
    end

    repeat (4) @(posedge clk);
    if (exp_bundle_q.size() != 0)
    begin
      $display("%0d instructions were never issued", exp_bundle_q.size());
      $display("Testbench failed");
      $fatal(1, "missing issues");
    end
    else
    begin
      $display("Testbench passed");
      $finish;
    end
  end

endmodule

//--- src.f
+incdir+tb
source/decode_pkg.sv
source/issue_pkg.sv
source/wave_stage_flops.sv
source/decode_core.sv
source/flag_generator.sv
source/reg_field_encoder.sv
source/instr_collate.sv
source/decode.sv
tb/tb_decode.sv

//--- Bender.yml
package:
  name: simt_decode

sources:
  - files:
      - source/decode_pkg.sv
      - source/issue_pkg.sv
      - source/wave_stage_flops.sv
      - source/decode_core.sv
      - source/flag_generator.sv
      - source/reg_field_encoder.sv
      - source/instr_collate.sv
      - source/decode.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/tb_decode.sv
